//--- gem_board_display.f
+incdir+bench
logic/gem_pkg.sv
logic/board_write_if.sv
logic/gem_lfsr.sv
logic/board_filler.sv
logic/board_store.sv
logic/cell_locator.sv
logic/pixel_colorizer.sv
logic/gem_board_display.sv
bench/gem_board_display_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the gem board testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module gem_board_display_tb \
    -f gem_board_display.f \
    -o gem_board_display_sim

./obj_dir/gem_board_display_sim | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"
exit 0

//--- bench/gem_board_checks.svh
`ifndef GEM_BOARD_CHECKS_SVH
`define GEM_BOARD_CHECKS_SVH

////////////////////
// compare tasks

task automatic check_rgb(input rgb_t got, input rgb_t want, input string what);
    if (got !== want) begin
        rgb_errors++;
        $display("** Error at %0t: %s, graph_rgb %h expected %h", $time, what, got, want);
    end
endtask

task automatic check_level(input logic got, input logic want, input string what);
    if (got !== want) begin
        level_errors++;
        $display("** Error at %0t: %s, level %b expected %b", $time, what, got, want);
    end
endtask

////////////////////
// lfsr helpers

// model of the 3-bit gem source, x^3 + x^2 + 1, right shifting
function automatic lfsr_t next_gem_state(input lfsr_t s);
    lfsr_t n;
    n[2] = s[0];
    n[1] = s[2] ^ s[0];
    n[0] = s[1];
    return n;
endfunction

// 8-bit stimulus lfsr, x^8 + x^6 + x^5 + x^4 + 1
function automatic logic [7:0] next_stim_state(input logic [7:0] s);
    logic [7:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 8'hB8;
    end
    return n;
endfunction

// one lfsr step per bit, msb first
task automatic take_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
        value = (value << 1) | int'(stim_lfsr[0]);
        stim_lfsr = next_stim_state(stim_lfsr);
    end
endtask

////////////////////
// waits

// starts right after the reset release edge
task automatic wait_fill_done(input int expect_cycles);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < FILL_TIMEOUT) begin
        @(negedge clk);
        check_level(filling, cycles < expect_cycles,
                    $sformatf("filling after %0d fill edges", cycles));
        if (!filling) begin
            done = 1'b1;
        end else begin
            @(posedge clk);
            cycles++;
        end
    end
    if (!done) begin
        timeout_errors++;
        $display("filling did not fall within %0d cycles after reset release", FILL_TIMEOUT);
    end
endtask

`endif

//--- bench/gem_board_display_tb.sv
module gem_board_display_tb import gem_pkg::*; ();

    // board geometry, default parameters of the dut
    localparam int    BX0          = 272;
    localparam int    BY0          = 112;
    localparam int    CELL         = 32;
    localparam int    INSET        = 4;
    localparam int    DIM          = 8;
    localparam lfsr_t SEED         = 3'd1;
    localparam int    RESET_CYCLES = 8;
    localparam int    FILL_TIMEOUT = 200;

    localparam rgb_t WHITE = 12'hFFF;
    localparam rgb_t BLACK = 12'h000;

    typedef struct packed {
        pix_coord_t x;
        pix_coord_t y;
        logic       von;
        rgb_t       want;
    } stim_t;

    logic       clk;
    logic       game_reset;
    logic       video_on;
    pix_coord_t pix_x;
    pix_coord_t pix_y;
    rgb_t       graph_rgb;
    logic       filling;

    int         rgb_errors = 0;
    int         level_errors = 0;
    int         timeout_errors = 0;
    logic [7:0] stim_lfsr;

    // expected board, [row][col]
    gem_t       model_gem [DIM][DIM];
    int         model_fill_cycles;
    stim_t      stim_tab [$];

    gem_board_display i_dut (
        .clk        (clk),
        .game_reset (game_reset),
        .video_on   (video_on),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .graph_rgb  (graph_rgb),
        .filling    (filling)
    );

    `include "gem_board_checks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // reference model

    function automatic rgb_t palette_of(input gem_t g);
        case (g)
            3'd0:    return 12'hF00;
            3'd1:    return 12'h0F0;
            3'd2:    return 12'h00F;
            3'd3:    return 12'hFF0;
            3'd4:    return 12'hF0F;
            // kinds 5 to 7 never occur
            default: return BLACK;
        endcase
    endfunction

    function automatic rgb_t expected_rgb(input int x, input int y, input logic von);
        int ox;
        int oy;
        int px;
        int py;
        ox = x - BX0;
        oy = y - BY0;
        if (!von) begin
            return BLACK;
        end
        if (ox < 0 || oy < 0 || ox >= DIM * CELL || oy >= DIM * CELL) begin
            return WHITE;
        end
        px = ox % CELL;
        py = oy % CELL;
        if (px >= INSET && px <= CELL - INSET - 1 && py >= INSET && py <= CELL - INSET - 1) begin
            return palette_of(model_gem[oy / CELL][ox / CELL]);
        end
        return WHITE;
    endfunction

    // one lfsr step per clock, accepted values fill the next cell
    task automatic build_model();
        lfsr_t s;
        int    n;
        int    edges;
        s     = SEED;
        n     = 0;
        edges = 0;
        while (n < DIM * DIM) begin
            if (s <= 3'd5) begin
                model_gem[n / DIM][n % DIM] = gem_t'(s - 3'd1);
                n++;
            end
            s = next_gem_state(s);
            edges++;
        end
        model_fill_cycles = edges;
    endtask

    ////////////////////
    // stimulus table

    task automatic add_stim(input int x, input int y, input logic von);
        stim_t e;
        e.x    = pix_coord_t'(x);
        e.y    = pix_coord_t'(y);
        e.von  = von;
        e.want = expected_rgb(x, y, von);
        stim_tab.push_back(e);
    endtask

    task automatic build_table();
        int x0;
        int y0;
        int v;
        int ox;
        int oy;
        // centre and one random gem pixel of every cell
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                x0 = BX0 + c * CELL;
                y0 = BY0 + r * CELL;
                add_stim(x0 + CELL / 2, y0 + CELL / 2, 1'b1);
                take_bits(5, v);
                ox = INSET + v % (CELL - 2 * INSET);
                take_bits(5, v);
                oy = INSET + v % (CELL - 2 * INSET);
                add_stim(x0 + ox, y0 + oy, 1'b1);
            end
        end
        // margins and square corners along the anti-diagonal
        for (int i = 0; i < DIM; i++) begin
            x0 = BX0 + (DIM - 1 - i) * CELL;
            y0 = BY0 + i * CELL;
            add_stim(x0 + INSET - 1, y0 + CELL / 2, 1'b1);
            add_stim(x0 + CELL - INSET, y0 + CELL / 2, 1'b1);
            add_stim(x0 + CELL / 2, y0, 1'b1);
            add_stim(x0 + CELL / 2, y0 + CELL - 1, 1'b1);
            add_stim(x0 + INSET, y0 + INSET, 1'b1);
            add_stim(x0 + CELL - INSET - 1, y0 + CELL - INSET - 1, 1'b1);
        end
        // just outside the board
        add_stim(0, 0, 1'b1);
        add_stim(BX0 - 1, BY0 + 100, 1'b1);
        add_stim(BX0 + DIM * CELL, BY0 + 100, 1'b1);
        add_stim(BX0 + 100, BY0 - 1, 1'b1);
        add_stim(BX0 + 100, BY0 + DIM * CELL, 1'b1);
        add_stim(639, 479, 1'b1);
        add_stim(1023, 1023, 1'b1);
        // blanking over gem squares and background
        for (int i = 0; i < DIM; i++) begin
            add_stim(BX0 + i * CELL + CELL / 2, BY0 + i * CELL + CELL / 2, 1'b0);
        end
        add_stim(0, 0, 1'b0);
    endtask

    ////////////////////
    // sequences

    task automatic hold_reset();
        @(posedge clk);
        game_reset <= 1'b1;
        video_on   <= 1'b1;
        pix_x      <= pix_coord_t'(BX0 + CELL / 2);
        pix_y      <= pix_coord_t'(BY0 + CELL / 2);
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_level(filling, 1'b1, "filling during reset");
            check_rgb(graph_rgb, BLACK, "graph_rgb during reset");
        end
        @(posedge clk);
        game_reset <= 1'b0;
    endtask

    // one entry per clock, each result checked a cycle later
    task automatic apply_table(input string pass_name);
        stim_t e;
        for (int i = 0; i <= stim_tab.size(); i++) begin
            @(posedge clk);
            if (i < stim_tab.size()) begin
                e = stim_tab[i];
                pix_x    <= e.x;
                pix_y    <= e.y;
                video_on <= e.von;
            end
            @(negedge clk);
            check_level(filling, 1'b0, "filling during display");
            if (i > 0) begin
                e = stim_tab[i - 1];
                check_rgb(graph_rgb, e.want,
                          $sformatf("%s entry %0d at (%0d,%0d) video_on %b",
                                    pass_name, i - 1, e.x, e.y, e.von));
            end
        end
    endtask

    initial begin
        game_reset <= 1'b1;
        video_on   <= 1'b0;
        pix_x      <= '0;
        pix_y      <= '0;
        stim_lfsr = 8'd29;

        build_model();
        build_table();

        hold_reset();
        wait_fill_done(model_fill_cycles);
        apply_table("first fill");

        // seed reload gives the same board
        hold_reset();
        wait_fill_done(model_fill_cycles);
        apply_table("refill");

        $display("errors: rgb %0d, level %0d, timeout %0d",
                 rgb_errors, level_errors, timeout_errors);
        if (rgb_errors + level_errors + timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- logic/gem_board_display.sv
module gem_board_display import gem_pkg::*; #(
    parameter lfsr_t LFSR_SEED    = 3'd1,
    parameter int    BOARD_X0     = 272,
    parameter int    BOARD_Y0     = 112,
    parameter int    CELL_SIZE    = 32,
    parameter int    SYMBOL_INSET = 4
) (
    input  logic       clk,
    input  logic       game_reset,
    input  logic       video_on,
    input  pix_coord_t pix_x,
    input  pix_coord_t pix_y,
    output rgb_t       graph_rgb,
    output logic       filling
);

    lfsr_t     random;
    cell_idx_t rd_row;
    cell_idx_t rd_col;
    gem_t      rd_gem;
    logic      in_symbol;

    board_write_if board_wr ();

    ////////////////////
    // fill path

    gem_lfsr #(
        .LFSR_SEED (LFSR_SEED)
    ) i_lfsr (
        .clk        (clk),
        .game_reset (game_reset),
        .random     (random)
    );

    board_filler i_filler (
        .clk        (clk),
        .game_reset (game_reset),
        .random     (random),
        .wr         (board_wr.writer),
        .filling    (filling)
    );

    board_store i_store (
        .clk        (clk),
        .game_reset (game_reset),
        .wr         (board_wr.store),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .rd_gem     (rd_gem)
    );

    ////////////////////
    // pixel path

    cell_locator #(
        .BOARD_X0     (BOARD_X0),
        .BOARD_Y0     (BOARD_Y0),
        .CELL_SIZE    (CELL_SIZE),
        .SYMBOL_INSET (SYMBOL_INSET)
    ) i_locator (
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .cell_row  (rd_row),
        .cell_col  (rd_col),
        .in_symbol (in_symbol)
    );

    pixel_colorizer i_colorizer (
        .clk        (clk),
        .game_reset (game_reset),
        .video_on   (video_on),
        .in_symbol  (in_symbol),
        .gem        (rd_gem),
        .graph_rgb  (graph_rgb)
    );

endmodule

//--- logic/pixel_colorizer.sv
module pixel_colorizer import gem_pkg::*; (
    input  logic clk,
    input  logic game_reset,
    input  logic video_on,
    input  logic in_symbol,
    input  gem_t gem,
    output rgb_t graph_rgb
);

    rgb_t rgb_next;

    ////////////////////
    // colour select

    // blanking wins over everything else
    always_comb begin
        if (!video_on) begin
            rgb_next = COLOR_BLACK;
        end else if (in_symbol) begin
            rgb_next = GEM_PALETTE[gem];
        end else begin
            rgb_next = COLOR_WHITE;
        end
    end

    ////////////////////
    // output register

    // one cycle from pixel position to colour
    always_ff @(posedge clk or posedge game_reset) begin
        if (game_reset) begin
            graph_rgb <= COLOR_BLACK;
        end else begin
            graph_rgb <= rgb_next;
        end
    end

endmodule

//--- logic/cell_locator.sv
module cell_locator import gem_pkg::*; #(
    parameter int BOARD_X0     = 272,
    parameter int BOARD_Y0     = 112,
    parameter int CELL_SIZE    = 32,
    parameter int SYMBOL_INSET = 4
) (
    input  pix_coord_t pix_x,
    input  pix_coord_t pix_y,
    output cell_idx_t  cell_row,
    output cell_idx_t  cell_col,
    output logic       in_symbol
);

    // cell edge is a power of two, so the index is a plain shift
    localparam int CELL_SHIFT = $clog2(CELL_SIZE);
    localparam int BOARD_SPAN = BOARD_DIM * CELL_SIZE;

    localparam pix_coord_t X_LO     = pix_coord_t'(BOARD_X0);
    localparam pix_coord_t X_HI     = pix_coord_t'(BOARD_X0 + BOARD_SPAN);
    localparam pix_coord_t Y_LO     = pix_coord_t'(BOARD_Y0);
    localparam pix_coord_t Y_HI     = pix_coord_t'(BOARD_Y0 + BOARD_SPAN);
    localparam pix_coord_t POS_MASK = pix_coord_t'(CELL_SIZE - 1);
    localparam pix_coord_t SYM_LO   = pix_coord_t'(SYMBOL_INSET);
    localparam pix_coord_t SYM_HI   = pix_coord_t'(CELL_SIZE - SYMBOL_INSET - 1);

    pix_coord_t off_x;
    pix_coord_t off_y;
    pix_coord_t pos_x;
    pix_coord_t pos_y;
    logic       on_board;
    logic       sym_x;
    logic       sym_y;

    // offset from board origin, only meaningful when on_board
    assign off_x = pix_x - X_LO;
    assign off_y = pix_y - Y_LO;

    assign on_board = (pix_x >= X_LO) && (pix_x < X_HI) &&
                      (pix_y >= Y_LO) && (pix_y < Y_HI);

    ////////////////////
    // cell index and in-cell position

    assign cell_col = cell_idx_t'(off_x >> CELL_SHIFT);
    assign cell_row = cell_idx_t'(off_y >> CELL_SHIFT);

    assign pos_x = off_x & POS_MASK;
    assign pos_y = off_y & POS_MASK;

    // gem square, inset on all four sides
    assign sym_x = (pos_x >= SYM_LO) && (pos_x <= SYM_HI);
    assign sym_y = (pos_y >= SYM_LO) && (pos_y <= SYM_HI);

    assign in_symbol = on_board && sym_x && sym_y;

endmodule

//--- logic/board_store.sv
module board_store import gem_pkg::*; (
    input  logic         clk,
    input  logic         game_reset,
    board_write_if.store wr,
    input  cell_idx_t    rd_row,
    input  cell_idx_t    rd_col,
    output gem_t         rd_gem
);

    // [row][col]
    gem_t cells [BOARD_DIM][BOARD_DIM];

    ////////////////////
    // write port

    always_ff @(posedge clk or posedge game_reset) begin
        if (game_reset) begin
            for (int r = 0; r < BOARD_DIM; r++) begin
                for (int c = 0; c < BOARD_DIM; c++) begin
                    cells[r][c] <= '0;
                end
            end
        end else if (wr.we) begin
            cells[wr.row][wr.col] <= wr.gem;
        end
    end

    ////////////////////
    // read port

    // straight from the pixel path, no register
    assign rd_gem = cells[rd_row][rd_col];

endmodule

//--- logic/board_filler.sv
module board_filler import gem_pkg::*; (
    input  logic          clk,
    input  logic          game_reset,
    input  lfsr_t         random,
    board_write_if.writer wr,
    output logic          filling
);

    localparam cell_idx_t LAST_IDX = cell_idx_t'(BOARD_DIM - 1);

    // lfsr runs 1..7, values 1..GEM_KINDS map onto gems 0..GEM_KINDS-1
    localparam lfsr_t ACCEPT_MAX = lfsr_t'(GEM_KINDS);

    fill_state_t state;
    cell_idx_t   row;
    cell_idx_t   col;
    logic        accept;
    logic        last_cell;

    ////////////////////
    // write decision

    // values above ACCEPT_MAX are skipped, retry next clock
    assign accept    = (state == FILL) && (random <= ACCEPT_MAX);
    assign last_cell = (row == LAST_IDX) && (col == LAST_IDX);

    assign wr.we  = accept;
    assign wr.row = row;
    assign wr.col = col;
    assign wr.gem = gem_t'(random - lfsr_t'(1));

    assign filling = (state == FILL);

    ////////////////////
    // cell walk

    // row by row, column fastest
    always_ff @(posedge clk or posedge game_reset) begin
        if (game_reset) begin
            state <= FILL;
            row   <= '0;
            col   <= '0;
        end else if (accept) begin
            if (last_cell) begin
                state <= DONE;
            end
            if (col == LAST_IDX) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

//--- logic/gem_lfsr.sv
module gem_lfsr import gem_pkg::*; #(
    parameter lfsr_t LFSR_SEED = 3'd1
) (
    input  logic  clk,
    input  logic  game_reset,
    output lfsr_t random
);

    // galois taps for x^3 + x^2 + 1, right shifting
    localparam lfsr_t TAPS = 3'b110;

    lfsr_t state;
    lfsr_t state_next;

    // shift right, fold the output bit back through the taps
    always_comb begin
        state_next = state >> 1;
        if (state[0]) begin
            state_next = state_next ^ TAPS;
        end
    end

    always_ff @(posedge clk or posedge game_reset) begin
        if (game_reset) begin
            state <= LFSR_SEED;
        end else begin
            state <= state_next;
        end
    end

    assign random = state;

endmodule

//--- logic/board_write_if.sv
interface board_write_if import gem_pkg::*; ();

    // single cell write, taken on any clock edge with we high
    logic      we;
    cell_idx_t row;
    cell_idx_t col;
    gem_t      gem;

    modport writer (
        output we,
        output row,
        output col,
        output gem
    );

    modport store (
        input we,
        input row,
        input col,
        input gem
    );

endinterface

//--- logic/gem_pkg.sv
package gem_pkg;

    ////////////////////
    // board geometry

    // rows and columns of the square board
    localparam int BOARD_DIM = 8;

    // number of distinct gem kinds
    localparam int GEM_KINDS = 5;

    ////////////////////
    // vector types

    // row or column index
    typedef logic [2:0] cell_idx_t;

    // gem kind, 0 to GEM_KINDS-1
    typedef logic [2:0] gem_t;

    // lfsr state, never zero
    typedef logic [2:0] lfsr_t;

    // screen x or y position
    typedef logic [9:0] pix_coord_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

    ////////////////////
    // fill fsm

    typedef enum logic {
        FILL,
        DONE
    } fill_state_t;

    ////////////////////
    // colours

    localparam rgb_t COLOR_WHITE = 12'hFFF;
    localparam rgb_t COLOR_BLACK = 12'h000;

    // one entry per gem kind
    localparam rgb_t GEM_PALETTE [GEM_KINDS] = '{
        12'hF00,
        12'h0F0,
        12'h00F,
        12'hFF0,
        12'hF0F
    };

endpackage
